// File: build.f
arcade_pkg.sv
rom_port_adapter.sv
reset_sequencer.sv
key_decoder.sv
input_mapper.sv
pedal_wheel_control.sv
arcade_host_glue.sv
tb_arcade_host_glue.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_arcade_host_glue -f build.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: tb_arcade_host_glue.sv
// arcade host glue testbench
`timescale 1ns/1ns

module tb_arcade_host_glue;

	localparam int dl_writes     = 64;
	localparam int frame_len     = 8;   // clocks per video frame
	localparam int dl_cycles     = dl_writes * 3 + 10;
	localparam int read_cycles   = 120;
	localparam int reset_cycles  = 3 * (arcade_pkg::reset_hold + 30);
	localparam int key_cycles    = 16 * 2 * 3 + 20;
	localparam int map_cycles    = 4 * 50 + 10;
	localparam int pedal_cycles  = 600 * frame_len + 20;
	localparam int watchdog_cycles = dl_cycles + read_cycles + reset_cycles
		+ key_cycles + map_cycles + pedal_cycles + 2000;

	logic clk_sys;
	logic rst_n;
	logic dl_active, dl_wr;
	arcade_pkg::dl_addr_t dl_addr;
	arcade_pkg::byte_t dl_data;
	arcade_pkg::rom_addr_t rom_addr;
	arcade_pkg::snd_addr_t snd_addr;
	logic [14:0] sp_addr;
	arcade_pkg::word_t prog_q, snd_q;
	logic menu_reset, button_reset;
	logic key_strobe, key_pressed;
	arcade_pkg::byte_t key_code;
	arcade_pkg::joy_t joy_0, joy_1;
	logic swap_joy, rotate, vsync;
	logic prog_req, prog_we, gfx_req, gfx_we;
	arcade_pkg::mem_addr_t prog_waddr;
	logic [1:0] prog_be, gfx_be;
	arcade_pkg::word_t prog_wdata, gfx_wdata;
	logic [15:0] gfx_waddr, prog_raddr, snd_raddr;
	logic [14:0] gfx_raddr;
	arcade_pkg::byte_t cpu_rom_byte, snd_rom_byte;
	logic rom_loaded, game_reset;
	logic m_up, m_down, m_left, m_right, m_fire1, m_fire2, m_fire3;
	logic m_coin, m_start1, m_start2;
	arcade_pkg::ctrl_t gas, steering;

	int errors;
	int seed;
	int low_count;                 // clocks game_reset has been low
	int reset_rises;               // rising edges of game_reset
	logic gr_d;
	logic wr_d, vs_d1, vs_d2, tick;
	arcade_pkg::key_buttons_t kb_exp;
	arcade_pkg::dl_addr_t gfx_off;
	arcade_pkg::joy_t ja, jb;
	logic [9:0] map_exp, mapped;
	arcade_pkg::ctrl_t gas_exp, steer_exp;

	arcade_host_glue uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==============================
	// expected values
	// ==============================
	always @(posedge clk_sys) begin
		wr_d  <= dl_wr;
		vs_d1 <= vsync;
		vs_d2 <= vs_d1;
		low_count <= game_reset ? 0 : low_count + 1;
		gr_d <= game_reset;
		if (rst_n && game_reset && !gr_d)
			reset_rises <= reset_rises + 1;
	end
	assign tick = vs_d1 & ~vs_d2; // frame edge as the controller sees it

	assign gfx_off = dl_addr - 25'h001_0000;
	assign ja = swap_joy ? joy_1 : joy_0;
	assign jb = swap_joy ? joy_0 : joy_1;

	always_comb begin
		logic u, d, l, r;
		u = kb_exp[0] | ja[3] | jb[3];
		d = kb_exp[1] | ja[2] | jb[2];
		l = kb_exp[2] | ja[1] | jb[1];
		r = kb_exp[3] | ja[0] | jb[0];
		map_exp[9] = rotate ? u : l;
		map_exp[8] = rotate ? d : r;
		map_exp[7] = rotate ? l : d;
		map_exp[6] = rotate ? r : u;
		map_exp[5] = kb_exp[7] | ja[4] | jb[4];
		map_exp[4] = kb_exp[8] | ja[5] | jb[5];
		map_exp[3] = kb_exp[9] | ja[6] | jb[6];
		map_exp[2:0] = {kb_exp[4], kb_exp[5], kb_exp[6]};
	end
	assign mapped = {m_up, m_down, m_left, m_right, m_fire1, m_fire2, m_fire3,
		m_coin, m_start1, m_start2};

	always_comb begin
		gas_exp = gas;
		if (m_up && !m_down)
			gas_exp = (gas == 8'hff) ? 8'hff : gas + 8'd1;
		else if (m_down && !m_up)
			gas_exp = (gas == 8'h00) ? 8'h00 : gas - 8'd1;
		steer_exp = steering;
		if (m_right && !m_left)
			steer_exp = (steering == 8'hff) ? 8'hff : steering + 8'd1;
		else if (m_left && !m_right)
			steer_exp = (steering == 8'h00) ? 8'h00 : steering - 8'd1;
		else if (steering > 8'h80)
			steer_exp = steering - 8'd1; // back toward centre
		else if (steering < 8'h80)
			steer_exp = steering + 8'd1;
	end

	// ==============================
	// checks
	// ==============================
	a_req_toggle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(dl_active && dl_wr && !wr_d) |=> ($changed(prog_req) && $changed(gfx_req)))
		else begin errors++; $display("ERR %0t: requests did not toggle on a write", $time); end
	a_req_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(dl_active && dl_wr && !wr_d) |=> ($stable(prog_req) && $stable(gfx_req)))
		else begin errors++; $display("ERR %0t: request toggled without a write", $time); end
	a_wr_fields: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_active |-> (prog_we && gfx_we && prog_waddr == dl_addr[23:1]
		&& prog_be == {dl_addr[0], ~dl_addr[0]} && prog_wdata == {dl_data, dl_data}
		&& gfx_waddr == {gfx_off[14:0], gfx_off[16]}
		&& gfx_be == {gfx_off[15], ~gfx_off[15]} && gfx_wdata == {dl_data, dl_data}))
		else begin errors++; $display("ERR %0t: wrong write address, enables or data", $time); end
	a_rd_parked: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_active |-> (prog_raddr == 16'hffff && snd_raddr == 16'hffff
		&& gfx_raddr == 15'h7fff))
		else begin errors++; $display("ERR %0t: read address not parked", $time); end
	a_rd_steer: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!dl_active |-> (!prog_we && !gfx_we && prog_raddr == {2'b00, rom_addr[14:1]}
		&& snd_raddr == 16'h4000 + {3'b000, snd_addr[13:1]} && gfx_raddr == sp_addr))
		else begin errors++; $display("ERR %0t: wrong read address or write enable", $time); end
	a_rd_byte: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(cpu_rom_byte == (rom_addr[0] ? prog_q[15:8] : prog_q[7:0])
		&& snd_rom_byte == (snd_addr[0] ? snd_q[15:8] : snd_q[7:0])))
		else begin errors++; $display("ERR %0t: wrong byte selected", $time); end
	a_loaded: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(dl_active) |=> rom_loaded)
		else begin errors++; $display("ERR %0t: rom_loaded late", $time); end
	a_hold_unloaded: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!rom_loaded |-> game_reset)
		else begin errors++; $display("ERR %0t: game out of reset before load", $time); end
	a_late_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		($rose(game_reset) && !$past(menu_reset) && !$past(button_reset))
		|-> low_count == arcade_pkg::reset_hold - 1)
		else begin errors++; $display("ERR %0t: late pulse after %0d low clocks", $time, low_count); end
	a_pulse_width: assert property (@(posedge clk_sys) disable iff (!rst_n)
		($rose(game_reset) && !$past(menu_reset) && !$past(button_reset)
		&& !menu_reset && !button_reset) |=> !game_reset)
		else begin errors++; $display("ERR %0t: late pulse longer than one clock", $time); end
	a_cause_reset: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(menu_reset || button_reset) |=> game_reset)
		else begin errors++; $display("ERR %0t: reset request ignored", $time); end
	a_map: assert property (@(posedge clk_sys) disable iff (!rst_n) mapped == map_exp)
		else begin errors++; $display("ERR %0t: mapped %b expected %b", $time, mapped, map_exp); end
	a_frame_step: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tick |=> (gas == $past(gas_exp) && steering == $past(steer_exp)))
		else begin errors++; $display("ERR %0t: gas %h steering %h", $time, gas, steering); end
	a_frame_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!tick |=> ($stable(gas) && $stable(steering)))
		else begin errors++; $display("ERR %0t: control moved between frames", $time); end

	// ==============================
	// stimulus
	// ==============================
	task automatic strobe_key(input arcade_pkg::byte_t code, input logic pressed,
		input int idx);
		@(posedge clk_sys);
		key_code <= code;
		key_pressed <= pressed;
		key_strobe <= 1'b1;
		@(posedge clk_sys);
		key_strobe <= 1'b0;
		if (idx >= 0)
			kb_exp[idx] <= pressed; // latch shows up now
		@(posedge clk_sys);
	endtask

	task automatic run_frames(input int n);
		repeat (n) begin
			@(posedge clk_sys) vsync <= 1'b1;
			repeat (2) @(posedge clk_sys);
			vsync <= 1'b0;
			repeat (frame_len - 3) @(posedge clk_sys);
		end
	endtask

	initial begin
		arcade_pkg::byte_t codes [10];
		codes = '{arcade_pkg::key_up, arcade_pkg::key_down, arcade_pkg::key_left,
			arcade_pkg::key_right, arcade_pkg::key_esc, arcade_pkg::key_f1,
			arcade_pkg::key_f2, arcade_pkg::key_space, arcade_pkg::key_alt,
			arcade_pkg::key_ctrl};
		errors = 0;
		seed = 32'hce1b_d4ef;
		low_count = 0;
		reset_rises = 0;
		kb_exp = '0;
		rst_n <= 1'b0;
		{dl_active, dl_wr, menu_reset, button_reset, key_strobe, key_pressed} <= '0;
		{dl_addr, dl_data, rom_addr, snd_addr, sp_addr, prog_q, snd_q} <= '0;
		{key_code, joy_0, joy_1, swap_joy, vsync} <= '0;
		rotate <= 1'b1;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;

		@(posedge clk_sys) dl_active <= 1'b1;
		for (int i = 0; i < dl_writes; i++) begin
			@(posedge clk_sys);
			dl_addr <= (i % 2) ? 25'h001_0000 + 25'($random(seed) & 32'hffff)
				: 25'($random(seed));
			dl_data <= 8'($random(seed));
			dl_wr <= 1'b1;
			@(posedge clk_sys) dl_wr <= 1'b0;
			@(posedge clk_sys);
		end
		@(posedge clk_sys) dl_active <= 1'b0;
		$display("test 1 download writes done, errors %0d", errors);

		repeat (100) begin
			@(posedge clk_sys);
			rom_addr <= 15'($random(seed));
			snd_addr <= 14'($random(seed));
			sp_addr  <= 15'($random(seed));
			prog_q   <= 16'($random(seed));
			snd_q    <= 16'($random(seed));
		end
		$display("test 2 read path done, errors %0d", errors);

		repeat (arcade_pkg::reset_hold + 10) @(posedge clk_sys);
		@(posedge clk_sys) menu_reset <= 1'b1;
		repeat (3) @(posedge clk_sys);
		menu_reset <= 1'b0;
		repeat (arcade_pkg::reset_hold + 10) @(posedge clk_sys);
		button_reset <= 1'b1;
		repeat (3) @(posedge clk_sys);
		button_reset <= 1'b0;
		repeat (arcade_pkg::reset_hold + 10) @(posedge clk_sys);
		// three late pulses plus one rise per reset request
		a_pulse_count: assert (reset_rises == 5)
			else begin
				errors++;
				$display("ERR %0t: game_reset rose %0d times, expected 5", $time, reset_rises);
			end
		$display("test 3 reset sequence done, errors %0d", errors);

		for (int i = 0; i < 10; i++) begin
			strobe_key(codes[i], 1'b1, i);
			strobe_key(codes[i], 1'b0, i);
		end
		strobe_key(8'h1c, 1'b1, -1);
		strobe_key(8'hf0, 1'b1, -1);
		strobe_key(8'h00, 1'b0, -1);
		$display("test 4 keyboard done, errors %0d", errors);

		for (int mode = 0; mode < 4; mode++) begin
			repeat (50) begin
				@(posedge clk_sys);
				swap_joy <= mode[0];
				rotate <= mode[1];
				joy_0 <= 8'($random(seed));
				joy_1 <= 8'($random(seed));
			end
		end
		@(posedge clk_sys);
		{joy_0, joy_1, swap_joy} <= '0;
		rotate <= 1'b1;
		$display("test 5 mapping done, errors %0d", errors);

		joy_0 <= 8'h08;  // hold up
		run_frames(300);
		joy_0 <= 8'h01;  // hold right
		run_frames(150);
		joy_0 <= 8'h00;
		run_frames(150);
		$display("test 6 gas and steering done, gas %h steering %h, errors %0d",
			gas, steering, errors);

		$display("tests 6, errors %0d", errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("timeout, the tests did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: arcade_host_glue.sv
// arcade host glue top level
`timescale 1ns/1ns

module arcade_host_glue (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	// host download
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  arcade_pkg::dl_addr_t  dl_addr,
	input  arcade_pkg::byte_t     dl_data,
	// game rom side
	input  arcade_pkg::rom_addr_t rom_addr,
	input  arcade_pkg::snd_addr_t snd_addr,
	input  logic [14:0]           sp_addr,
	input  arcade_pkg::word_t     prog_q,
	input  arcade_pkg::word_t     snd_q,
	// resets
	input  logic                  menu_reset,
	input  logic                  button_reset,
	// keyboard and joysticks
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  arcade_pkg::byte_t     key_code,
	input  arcade_pkg::joy_t      joy_0,
	input  arcade_pkg::joy_t      joy_1,
	input  logic                  swap_joy,
	input  logic                  rotate,
	input  logic                  vsync,
	// memory ports
	output logic                  prog_req,
	output logic                  prog_we,
	output arcade_pkg::mem_addr_t prog_waddr,
	output logic [1:0]            prog_be,
	output arcade_pkg::word_t     prog_wdata,
	output logic                  gfx_req,
	output logic                  gfx_we,
	output logic [15:0]           gfx_waddr,
	output logic [1:0]            gfx_be,
	output arcade_pkg::word_t     gfx_wdata,
	output logic [15:0]           prog_raddr,
	output logic [15:0]           snd_raddr,
	output logic [14:0]           gfx_raddr,
	output arcade_pkg::byte_t     cpu_rom_byte,
	output arcade_pkg::byte_t     snd_rom_byte,
	// game controls
	output logic                  rom_loaded,
	output logic                  game_reset,
	output logic                  m_up,
	output logic                  m_down,
	output logic                  m_left,
	output logic                  m_right,
	output logic                  m_fire1,
	output logic                  m_fire2,
	output logic                  m_fire3,
	output logic                  m_coin,
	output logic                  m_start1,
	output logic                  m_start2,
	output arcade_pkg::ctrl_t     gas,
	output arcade_pkg::ctrl_t     steering
);

	arcade_pkg::key_buttons_t key_buttons;

	// ==============================
	// download and reset
	// ==============================
	rom_port_adapter u_rom_port (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.rom_addr(rom_addr), .snd_addr(snd_addr), .sp_addr(sp_addr),
		.prog_q(prog_q), .snd_q(snd_q),
		.prog_req(prog_req), .prog_we(prog_we), .prog_waddr(prog_waddr),
		.prog_be(prog_be), .prog_wdata(prog_wdata),
		.gfx_req(gfx_req), .gfx_we(gfx_we), .gfx_waddr(gfx_waddr),
		.gfx_be(gfx_be), .gfx_wdata(gfx_wdata),
		.prog_raddr(prog_raddr), .snd_raddr(snd_raddr), .gfx_raddr(gfx_raddr),
		.cpu_rom_byte(cpu_rom_byte), .snd_rom_byte(snd_rom_byte)
	);

	reset_sequencer u_reset_seq (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_active(dl_active), .menu_reset(menu_reset), .button_reset(button_reset),
		.rom_loaded(rom_loaded), .game_reset(game_reset)
	);

	// ==============================
	// player inputs
	// ==============================
	key_decoder u_keys (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.key_buttons(key_buttons)
	);

	input_mapper u_mapper (
		.joy_0(joy_0), .joy_1(joy_1), .swap_joy(swap_joy), .rotate(rotate),
		.key_buttons(key_buttons),
		.m_up(m_up), .m_down(m_down), .m_left(m_left), .m_right(m_right),
		.m_fire1(m_fire1), .m_fire2(m_fire2), .m_fire3(m_fire3),
		.m_coin(m_coin), .m_start1(m_start1), .m_start2(m_start2)
	);

	// up and down work the pedal, left and right the wheel
	pedal_wheel_control u_pedal_wheel (
		.clk_sys(clk_sys), .rst_n(rst_n), .vsync(vsync),
		.gas_plus(m_up), .gas_minus(m_down),
		.steer_plus(m_right), .steer_minus(m_left),
		.gas(gas), .steering(steering)
	);

endmodule

// File: pedal_wheel_control.sv
// gas pedal and steering wheel control
`timescale 1ns/1ns

module pedal_wheel_control (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              vsync,
	input  logic              gas_plus,
	input  logic              gas_minus,
	input  logic              steer_plus,
	input  logic              steer_minus,
	output arcade_pkg::ctrl_t gas,
	output arcade_pkg::ctrl_t steering
);

	logic vsync_d;
	logic frame_tick;  // registered rising edge of vsync

	// ==============================
	// frame edge
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vsync_d    <= 1'b0;
			frame_tick <= 1'b0;
		end else begin
			vsync_d    <= vsync;
			frame_tick <= vsync & ~vsync_d;
		end
	end

	// ==============================
	// stepped values
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			gas      <= '0;
			steering <= arcade_pkg::steer_center;
		end else if (frame_tick) begin
			// gas holds when both or neither pedal input is set
			if (gas_plus && !gas_minus)
				gas <= (gas > 8'hff - arcade_pkg::gas_step) ? 8'hff : gas + arcade_pkg::gas_step;
			else if (gas_minus && !gas_plus)
				gas <= (gas < arcade_pkg::gas_step) ? 8'h00 : gas - arcade_pkg::gas_step;

			if (steer_plus && !steer_minus) begin
				if (steering > 8'hff - arcade_pkg::steer_step)
					steering <= 8'hff;
				else
					steering <= steering + arcade_pkg::steer_step;
			end else if (steer_minus && !steer_plus) begin
				if (steering < arcade_pkg::steer_step)
					steering <= 8'h00;
				else
					steering <= steering - arcade_pkg::steer_step;
			end else if (steering > arcade_pkg::steer_center) begin
				// drift back to centre, never past it
				if (steering - arcade_pkg::steer_center > arcade_pkg::steer_step)
					steering <= steering - arcade_pkg::steer_step;
				else
					steering <= arcade_pkg::steer_center;
			end else if (steering < arcade_pkg::steer_center) begin
				if (arcade_pkg::steer_center - steering > arcade_pkg::steer_step)
					steering <= steering + arcade_pkg::steer_step;
				else
					steering <= arcade_pkg::steer_center;
			end
		end
	end

	a_gas_on_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed(gas) |-> $past(frame_tick))
		else $error("gas moved without a frame edge");

endmodule

// File: input_mapper.sv
// joystick and keyboard input mapper
`timescale 1ns/1ns

module input_mapper (
	input  arcade_pkg::joy_t         joy_0,
	input  arcade_pkg::joy_t         joy_1,
	input  logic                     swap_joy,
	input  logic                     rotate,
	input  arcade_pkg::key_buttons_t key_buttons,
	output logic                     m_up,
	output logic                     m_down,
	output logic                     m_left,
	output logic                     m_right,
	output logic                     m_fire1,
	output logic                     m_fire2,
	output logic                     m_fire3,
	output logic                     m_coin,
	output logic                     m_start1,
	output logic                     m_start2
);

	arcade_pkg::joy_t joy_a;
	arcade_pkg::joy_t joy_b;
	logic             dir_up;
	logic             dir_down;
	logic             dir_left;
	logic             dir_right;

	assign joy_a = swap_joy ? joy_1 : joy_0;
	assign joy_b = swap_joy ? joy_0 : joy_1;

	// ==============================
	// merged directions
	// ==============================
	assign dir_up    = key_buttons[arcade_pkg::btn_up_i]    | joy_a[3] | joy_b[3];
	assign dir_down  = key_buttons[arcade_pkg::btn_down_i]  | joy_a[2] | joy_b[2];
	assign dir_left  = key_buttons[arcade_pkg::btn_left_i]  | joy_a[1] | joy_b[1];
	assign dir_right = key_buttons[arcade_pkg::btn_right_i] | joy_a[0] | joy_b[0];

	// rotate low means the cabinet is turned, so directions shift by 90 degrees
	assign m_up    = rotate ? dir_up    : dir_left;
	assign m_down  = rotate ? dir_down  : dir_right;
	assign m_left  = rotate ? dir_left  : dir_down;
	assign m_right = rotate ? dir_right : dir_up;

	// ==============================
	// buttons
	// ==============================
	assign m_fire1 = key_buttons[arcade_pkg::btn_fire1_i] | joy_a[4] | joy_b[4];
	assign m_fire2 = key_buttons[arcade_pkg::btn_fire2_i] | joy_a[5] | joy_b[5];
	assign m_fire3 = key_buttons[arcade_pkg::btn_fire3_i] | joy_a[6] | joy_b[6];

	assign m_coin   = key_buttons[arcade_pkg::btn_coin_i];   // keyboard only
	assign m_start1 = key_buttons[arcade_pkg::btn_start1_i];
	assign m_start2 = key_buttons[arcade_pkg::btn_start2_i];

endmodule

// File: key_decoder.sv
// keyboard scan code decoder
`timescale 1ns/1ns

module key_decoder (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      key_strobe,
	input  logic                      key_pressed,
	input  arcade_pkg::byte_t         key_code,
	output arcade_pkg::key_buttons_t  key_buttons
);

	// ==============================
	// button latch
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			key_buttons <= '0;
		end else if (key_strobe) begin
			case (key_code)
				arcade_pkg::key_up:
					key_buttons[arcade_pkg::btn_up_i] <= key_pressed;
				arcade_pkg::key_down:
					key_buttons[arcade_pkg::btn_down_i] <= key_pressed;
				arcade_pkg::key_left:
					key_buttons[arcade_pkg::btn_left_i] <= key_pressed;
				arcade_pkg::key_right:
					key_buttons[arcade_pkg::btn_right_i] <= key_pressed;
				arcade_pkg::key_esc:
					key_buttons[arcade_pkg::btn_coin_i] <= key_pressed;   // coin
				arcade_pkg::key_f1:
					key_buttons[arcade_pkg::btn_start1_i] <= key_pressed; // one player
				arcade_pkg::key_f2:
					key_buttons[arcade_pkg::btn_start2_i] <= key_pressed; // two players
				arcade_pkg::key_space:
					key_buttons[arcade_pkg::btn_fire1_i] <= key_pressed;
				arcade_pkg::key_alt:
					key_buttons[arcade_pkg::btn_fire2_i] <= key_pressed;  // left alt
				arcade_pkg::key_ctrl:
					key_buttons[arcade_pkg::btn_fire3_i] <= key_pressed;  // left ctrl
				default: begin
					// unmapped codes leave the buttons alone
				end
			endcase
		end
	end

endmodule

// File: reset_sequencer.sv
// game reset sequencer
`timescale 1ns/1ns

module reset_sequencer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic dl_active,
	input  logic menu_reset,
	input  logic button_reset,
	output logic rom_loaded,
	output logic game_reset
);

	logic                dl_active_d;
	logic                cause;
	arcade_pkg::hold_t   hold_cnt;

	assign cause = menu_reset | button_reset | ~rom_loaded;

	// ==============================
	// rom loaded flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_active_d <= 1'b0;
			rom_loaded  <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_active_d && !dl_active)
				rom_loaded <= 1'b1; // end of download, stays set
		end
	end

	// ==============================
	// hold counter and reset out
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hold_cnt   <= arcade_pkg::reset_hold;
			game_reset <= 1'b1;
		end else begin
			if (cause)
				hold_cnt <= arcade_pkg::reset_hold;
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			// second short pulse once the count runs out
			game_reset <= cause | (hold_cnt == arcade_pkg::hold_t'(1));
		end
	end

	a_reset_until_loaded: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!rom_loaded |-> game_reset)
		else $error("game left reset before rom was loaded");

endmodule

// File: rom_port_adapter.sv
// rom download and read port adapter
`timescale 1ns/1ns

module rom_port_adapter (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 dl_active,
	input  logic                 dl_wr,
	input  arcade_pkg::dl_addr_t dl_addr,
	input  arcade_pkg::byte_t    dl_data,
	input  arcade_pkg::rom_addr_t rom_addr,
	input  arcade_pkg::snd_addr_t snd_addr,
	input  logic [14:0]          sp_addr,
	input  arcade_pkg::word_t    prog_q,
	input  arcade_pkg::word_t    snd_q,
	output logic                 prog_req,
	output logic                 prog_we,
	output arcade_pkg::mem_addr_t prog_waddr,
	output logic [1:0]           prog_be,
	output arcade_pkg::word_t    prog_wdata,
	output logic                 gfx_req,
	output logic                 gfx_we,
	output logic [15:0]          gfx_waddr,
	output logic [1:0]           gfx_be,
	output arcade_pkg::word_t    gfx_wdata,
	output logic [15:0]          prog_raddr,
	output logic [15:0]          snd_raddr,
	output logic [14:0]          gfx_raddr,
	output arcade_pkg::byte_t    cpu_rom_byte,
	output arcade_pkg::byte_t    snd_rom_byte
);

	logic                 dl_wr_d;
	logic                 wr_rise;
	arcade_pkg::dl_addr_t gfx_off;

	// ==============================
	// write side
	// ==============================
	assign wr_rise = dl_active & dl_wr & ~dl_wr_d;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_wr_d  <= 1'b0;
			prog_req <= 1'b0;
			gfx_req  <= 1'b0;
		end else begin
			dl_wr_d <= dl_wr;
			if (wr_rise) begin
				prog_req <= ~prog_req; // each toggle is one write, no ack
				gfx_req  <= ~gfx_req;
			end
		end
	end

	assign prog_we    = dl_active;
	assign prog_waddr = dl_addr[23:1];
	assign prog_be    = {dl_addr[0], ~dl_addr[0]};
	assign prog_wdata = {dl_data, dl_data};

	// sprite roms merged into 32-bit words, bit 16 picks the half
	assign gfx_off   = dl_addr - arcade_pkg::gfx_base;
	assign gfx_we    = dl_active;
	assign gfx_waddr = {gfx_off[14:0], gfx_off[16]};
	assign gfx_be    = {gfx_off[15], ~gfx_off[15]};
	assign gfx_wdata = prog_wdata;

	// ==============================
	// read side
	// ==============================
	assign prog_raddr = dl_active ? 16'hffff : {2'b00, rom_addr[14:1]};
	assign snd_raddr  = dl_active ? 16'hffff : arcade_pkg::snd_base + {3'b000, snd_addr[13:1]};
	assign gfx_raddr  = dl_active ? 15'h7fff : sp_addr; // park reads during download

	assign cpu_rom_byte = rom_addr[0] ? prog_q[15:8] : prog_q[7:0];
	assign snd_rom_byte = snd_addr[0] ? snd_q[15:8] : snd_q[7:0];

	// requests only move while a download runs
	a_req_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		($changed(prog_req) || $changed(gfx_req)) |-> $past(dl_active))
		else $error("request toggled outside a download");

endmodule

// File: arcade_pkg.sv
// arcade host glue shared definitions
package arcade_pkg;

	// ==============================
	// widths
	// ==============================
	typedef logic [7:0]  byte_t;        // download data, key codes, rom bytes
	typedef logic [15:0] word_t;        // one memory word
	typedef logic [24:0] dl_addr_t;     // host byte address
	typedef logic [22:0] mem_addr_t;    // word address on the download port
	typedef logic [14:0] rom_addr_t;    // program rom byte address
	typedef logic [13:0] snd_addr_t;    // sound rom byte address
	typedef logic [7:0]  joy_t;         // 0 right, 1 left, 2 down, 3 up, 4..6 fire
	typedef logic [9:0]  key_buttons_t;
	typedef logic [15:0] hold_t;
	typedef logic [7:0]  ctrl_t;        // gas and steering

	// ==============================
	// keyboard buttons
	// ==============================
	localparam int btn_up_i     = 0;
	localparam int btn_down_i   = 1;
	localparam int btn_left_i   = 2;
	localparam int btn_right_i  = 3;
	localparam int btn_coin_i   = 4;
	localparam int btn_start1_i = 5;
	localparam int btn_start2_i = 6;
	localparam int btn_fire1_i  = 7;
	localparam int btn_fire2_i  = 8;
	localparam int btn_fire3_i  = 9;

	// ps/2 set 2 scan codes
	localparam byte_t key_up    = 8'h75;
	localparam byte_t key_down  = 8'h72;
	localparam byte_t key_left  = 8'h6b;
	localparam byte_t key_right = 8'h74;
	localparam byte_t key_esc   = 8'h76;
	localparam byte_t key_f1    = 8'h05;
	localparam byte_t key_f2    = 8'h06;
	localparam byte_t key_ctrl  = 8'h14;
	localparam byte_t key_alt   = 8'h11;
	localparam byte_t key_space = 8'h29;

	// ==============================
	// loader and control constants
	// ==============================
	localparam dl_addr_t gfx_base = 25'h001_0000; // sprite data start in the download
	localparam logic [15:0] snd_base = 16'h4000;  // sound rom word offset
	localparam hold_t reset_hold = 16'd200;
	localparam ctrl_t steer_center = 8'h80;
	localparam ctrl_t gas_step = 8'd1;
	localparam ctrl_t steer_step = 8'd1;

endpackage
